// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := mips_core_tb
FILELIST  := tb.f
BUILD_DIR := obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== src/decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_unit import mips_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n_i,
    input  wire logic   stall_i,
    input  wire if_id_t if_id_i,
    output reg_addr_t   raddr_a_o,
    output reg_addr_t   raddr_b_o,
    input  wire word_t  rdata_a_i,
    input  wire word_t  rdata_b_i,
    input  wire fwd_t   ex_fwd_i,
    input  wire fwd_t   wb_fwd_i,
    output logic        branch_taken_o,
    output word_t       branch_target_o,
    output id_ex_t      id_ex_o
);

    instr_u ins;
    word_t  rs_val;
    word_t  rt_val;
    word_t  imm_sext;
    word_t  imm_zext;
    word_t  pc_plus4;
    id_ex_t id_ex_d;
    id_ex_t id_ex_q;

    // newest producer wins, execute before writeback
    function automatic word_t forward(reg_addr_t addr, word_t rf_data, fwd_t ex_f, fwd_t wb_f);
        if (ex_f.we && ex_f.addr == addr) begin
            return ex_f.data;
        end
        if (wb_f.we && wb_f.addr == addr) begin
            return wb_f.data;
        end
        return rf_data;
    endfunction

    assign ins       = if_id_i.instr;
    assign raddr_a_o = ins.r.rs;
    assign raddr_b_o = ins.r.rt;

    assign rs_val   = forward(ins.r.rs, rdata_a_i, ex_fwd_i, wb_fwd_i);
    assign rt_val   = forward(ins.r.rt, rdata_b_i, ex_fwd_i, wb_fwd_i);
    assign imm_sext = {{16{ins.i.imm[15]}}, ins.i.imm};
    assign imm_zext = {16'h0000, ins.i.imm};
    assign pc_plus4 = if_id_i.pc + 32'd4;

    assign branch_target_o = pc_plus4 + {imm_sext[29:0], 2'b00};

    always_comb begin
        id_ex_d            = '0;
        id_ex_d.valid      = if_id_i.valid;
        id_ex_d.alu_op     = ALU_ADD;
        id_ex_d.operand_a  = rs_val;
        id_ex_d.operand_b  = rt_val;
        id_ex_d.store_data = rt_val;
        id_ex_d.wreg_addr  = ins.r.rd;
        branch_taken_o     = 1'b0;
        case (ins.r.opcode)
            OP_SPECIAL: begin
                id_ex_d.wreg_we = 1'b1;
                case (ins.r.funct)
                    FN_ADDU: id_ex_d.alu_op = ALU_ADD;
                    FN_SUBU: id_ex_d.alu_op = ALU_SUB;
                    FN_AND:  id_ex_d.alu_op = ALU_AND;
                    FN_OR:   id_ex_d.alu_op = ALU_OR;
                    FN_XOR:  id_ex_d.alu_op = ALU_XOR;
                    FN_SLT:  id_ex_d.alu_op = ALU_SLT;
                    default: id_ex_d.wreg_we = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                id_ex_d.operand_b = imm_sext;
                id_ex_d.wreg_we   = 1'b1;
                id_ex_d.wreg_addr = ins.i.rt;
            end
            OP_ORI: begin
                id_ex_d.alu_op    = ALU_OR;
                id_ex_d.operand_b = imm_zext;
                id_ex_d.wreg_we   = 1'b1;
                id_ex_d.wreg_addr = ins.i.rt;
            end
            OP_LUI: begin
                id_ex_d.alu_op    = ALU_LUI;
                id_ex_d.operand_b = imm_zext;
                id_ex_d.wreg_we   = 1'b1;
                id_ex_d.wreg_addr = ins.i.rt;
            end
            OP_BEQ: branch_taken_o = (rs_val == rt_val);
            OP_BNE: branch_taken_o = (rs_val != rt_val);
            OP_SW: begin
                // address is base plus signed offset
                id_ex_d.operand_b = imm_sext;
                id_ex_d.is_store  = 1'b1;
            end
            default: ;
        endcase
        // writes to r0 vanish here so forwarding never matches it
        id_ex_d.wreg_we  = id_ex_d.wreg_we & if_id_i.valid & (id_ex_d.wreg_addr != 5'd0);
        id_ex_d.is_store = id_ex_d.is_store & if_id_i.valid;
        branch_taken_o   = branch_taken_o & if_id_i.valid;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_ex_q.valid <= 1'b0;
        end else if (!stall_i) begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

// ==== src/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit import mips_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n_i,
    input  wire logic   stall_i,
    input  wire id_ex_t id_ex_i,
    output fwd_t        ex_fwd_o,
    output ex_wb_t      ex_wb_o
);

    word_t  alu_res;
    ex_wb_t ex_wb_q;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD: alu_res = id_ex_i.operand_a + id_ex_i.operand_b;
            ALU_SUB: alu_res = id_ex_i.operand_a - id_ex_i.operand_b;
            ALU_AND: alu_res = id_ex_i.operand_a & id_ex_i.operand_b;
            ALU_OR:  alu_res = id_ex_i.operand_a | id_ex_i.operand_b;
            ALU_XOR: alu_res = id_ex_i.operand_a ^ id_ex_i.operand_b;
            // signed compare
            ALU_SLT: begin
                alu_res = {31'd0, $signed(id_ex_i.operand_a) < $signed(id_ex_i.operand_b)};
            end
            ALU_LUI: alu_res = {id_ex_i.operand_b[15:0], 16'h0000};
            default: alu_res = '0;
        endcase
    end

    // result of the instruction now in execute, for decode
    always_comb begin
        ex_fwd_o.we   = id_ex_i.valid & id_ex_i.wreg_we;
        ex_fwd_o.addr = id_ex_i.wreg_addr;
        ex_fwd_o.data = alu_res;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_wb_q.valid <= 1'b0;
        end else if (!stall_i) begin
            ex_wb_q.valid <= id_ex_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            ex_wb_q.result     <= alu_res;
            ex_wb_q.store_data <= id_ex_i.store_data;
            ex_wb_q.wreg_we    <= id_ex_i.wreg_we;
            ex_wb_q.wreg_addr  <= id_ex_i.wreg_addr;
            ex_wb_q.is_store   <= id_ex_i.is_store;
        end
    end

    assign ex_wb_o = ex_wb_q;

endmodule

`default_nettype wire

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import mips_pkg::*; #(
    parameter word_t RESET_PC = RESET_PC_DEFAULT
) (
    input  wire logic    clk,
    input  wire logic    rst_n_i,
    input  wire logic    stall_i,
    input  wire logic    branch_taken_i,
    input  wire word_t   branch_target_i,
    output wb_req_t      ibus_req_o,
    input  wire wb_rsp_t ibus_rsp_i,
    output if_id_t       if_id_o
);

    logic   active_q;
    word_t  pc_q;
    logic   buf_valid_q;
    instr_u buf_instr_q;
    logic   redirect_q;
    word_t  redirect_pc_q;
    if_id_t if_id_q;
    logic   req_live;
    logic   ack_now;
    logic   advance;
    word_t  next_pc;

    // no new bus cycle while a fetched word waits in the buffer
    assign req_live = active_q & ~buf_valid_q;
    assign ack_now  = req_live & ibus_rsp_i.ack;
    assign advance  = ~stall_i & (buf_valid_q | ack_now);

    always_comb begin
        if (branch_taken_i) begin
            next_pc = branch_target_i;
        end else if (redirect_q) begin
            next_pc = redirect_pc_q;
        end else begin
            next_pc = pc_q + 32'd4;
        end
    end

    always_comb begin
        ibus_req_o.cyc = req_live;
        ibus_req_o.stb = req_live;
        ibus_req_o.we  = 1'b0;
        ibus_req_o.adr = pc_q;
        ibus_req_o.dat = '0;
        ibus_req_o.sel = 4'hf;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            active_q      <= 1'b0;
            pc_q          <= RESET_PC;
            buf_valid_q   <= 1'b0;
            redirect_q    <= 1'b0;
            if_id_q.valid <= 1'b0;
        end else begin
            active_q <= 1'b1;
            if (advance) begin
                pc_q        <= next_pc;
                buf_valid_q <= 1'b0;
                redirect_q  <= 1'b0;
            end else if (stall_i && ack_now) begin
                buf_valid_q <= 1'b1;
            end
            // branch left decode before its delay slot arrived
            if (branch_taken_i && !stall_i && !advance) begin
                redirect_q <= 1'b1;
            end
            if (!stall_i) begin
                if_id_q.valid <= advance;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stall_i && ack_now) begin
            buf_instr_q <= ibus_rsp_i.dat;
        end
        if (branch_taken_i && !stall_i) begin
            redirect_pc_q <= branch_target_i;
        end
        if (!stall_i) begin
            if_id_q.pc    <= pc_q;
            if_id_q.instr <= buf_valid_q ? buf_instr_q : ibus_rsp_i.dat;
        end
    end

    assign if_id_o = if_id_q;

    // an open fetch cycle keeps stb inside cyc and its address until ack
    a_stb_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        (ibus_req_o.stb && !ibus_rsp_i.ack) |=>
            (ibus_req_o.stb && ibus_req_o.cyc && $stable(ibus_req_o.adr)));

endmodule

`default_nettype wire

// ==== src/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core import mips_pkg::*; #(
    parameter word_t RESET_PC = RESET_PC_DEFAULT
) (
    input  wire logic    clk,
    input  wire logic    rst_n_i,
    output wb_req_t      ibus_req_o,
    input  wire wb_rsp_t ibus_rsp_i,
    output wb_req_t      dbus_req_o,
    input  wire wb_rsp_t dbus_rsp_i
);

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_wb_t    ex_wb;
    fwd_t      ex_fwd;
    fwd_t      wb_fwd;
    reg_addr_t raddr_a;
    reg_addr_t raddr_b;
    word_t     rdata_a;
    word_t     rdata_b;
    logic      branch_taken;
    word_t     branch_target;
    logic      store_busy;
    logic      stall;

    // only a pending data write holds the pipeline
    assign stall = store_busy;

    fetch_unit #(.RESET_PC(RESET_PC)) fetch_unit_i (
        .clk,
        .rst_n_i,
        .stall_i(stall),
        .branch_taken_i(branch_taken),
        .branch_target_i(branch_target),
        .ibus_req_o,
        .ibus_rsp_i,
        .if_id_o(if_id)
    );

    reg_file reg_file_i (
        .clk,
        .rst_n_i,
        .raddr_a_i(raddr_a),
        .raddr_b_i(raddr_b),
        .rdata_a_o(rdata_a),
        .rdata_b_o(rdata_b),
        .wr_i(wb_fwd)
    );

    decode_unit decode_unit_i (
        .clk,
        .rst_n_i,
        .stall_i(stall),
        .if_id_i(if_id),
        .raddr_a_o(raddr_a),
        .raddr_b_o(raddr_b),
        .rdata_a_i(rdata_a),
        .rdata_b_i(rdata_b),
        .ex_fwd_i(ex_fwd),
        .wb_fwd_i(wb_fwd),
        .branch_taken_o(branch_taken),
        .branch_target_o(branch_target),
        .id_ex_o(id_ex)
    );

    execute_unit execute_unit_i (
        .clk,
        .rst_n_i,
        .stall_i(stall),
        .id_ex_i(id_ex),
        .ex_fwd_o(ex_fwd),
        .ex_wb_o(ex_wb)
    );

    store_unit store_unit_i (
        .clk,
        .rst_n_i,
        .ex_wb_i(ex_wb),
        .dbus_req_o,
        .dbus_rsp_i,
        .store_busy_o(store_busy),
        .wb_fwd_o(wb_fwd)
    );

endmodule

`default_nettype wire

// ==== src/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam word_t RESET_PC_DEFAULT = 32'h0000_0000;

    // primary opcodes, anything else runs as a no-op
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field of SPECIAL
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] shamt;
        funct_e    funct;
    } r_instr_t;

    typedef struct packed {
        opcode_e     opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_instr_t;

    // same fetched word seen as R-type or I-type
    typedef union packed {
        r_instr_t r;
        i_instr_t i;
    } instr_u;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        word_t      adr;
        word_t      dat;
        logic [3:0] sel;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_u instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        word_t     operand_a;
        word_t     operand_b;
        word_t     store_data;
        logic      wreg_we;
        reg_addr_t wreg_addr;
        logic      is_store;
    } id_ex_t;

    // result carries the store address for SW
    typedef struct packed {
        logic      valid;
        word_t     result;
        word_t     store_data;
        logic      wreg_we;
        reg_addr_t wreg_addr;
        logic      is_store;
    } ex_wb_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } fwd_t;

endpackage

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file import mips_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n_i,
    input  wire reg_addr_t raddr_a_i,
    input  wire reg_addr_t raddr_b_i,
    output word_t          rdata_a_o,
    output word_t          rdata_b_o,
    input  wire fwd_t      wr_i
);

    word_t regs_q [32];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.we && wr_i.addr != 5'd0) begin
            regs_q[wr_i.addr] <= wr_i.data;
        end
    end

    // r0 is never written so it reads back zero
    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== src/store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_unit import mips_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n_i,
    input  wire ex_wb_t  ex_wb_i,
    output wb_req_t      dbus_req_o,
    input  wire wb_rsp_t dbus_rsp_i,
    output logic         store_busy_o,
    output fwd_t         wb_fwd_o
);

    logic store_req;

    // ex_wb stays frozen by the stall until ack, so the request holds
    assign store_req = ex_wb_i.valid & ex_wb_i.is_store;

    always_comb begin
        dbus_req_o.cyc = store_req;
        dbus_req_o.stb = store_req;
        dbus_req_o.we  = store_req;
        dbus_req_o.adr = ex_wb_i.result;
        dbus_req_o.dat = ex_wb_i.store_data;
        dbus_req_o.sel = 4'hf;
    end

    // released in the ack cycle so a following store can start at once
    assign store_busy_o = store_req & ~dbus_rsp_i.ack;

    always_comb begin
        wb_fwd_o.we   = ex_wb_i.valid & ex_wb_i.wreg_we & ~ex_wb_i.is_store;
        wb_fwd_o.addr = ex_wb_i.wreg_addr;
        wb_fwd_o.data = ex_wb_i.result;
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (dbus_req_o.cyc && !dbus_rsp_i.ack) |=> $stable(dbus_req_o));

endmodule

`default_nettype wire

// ==== tb.f ====
src/mips_pkg.sv
src/fetch_unit.sv
src/reg_file.sv
src/decode_unit.sv
src/execute_unit.sv
src/store_unit.sv
src/mips_core.sv
verification/tb_clock.sv
verification/wb_memory_model.sv
verification/mips_core_tb.sv

// ==== verification/mips_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb import mips_pkg::*; ();

    // summed length of all runs is about 500 cycles with random waits
    localparam int    TEST_CYCLES    = 500;
    localparam int    TIMEOUT_CYCLES = 4 * TEST_CYCLES;
    localparam word_t DONE_ADR       = 32'h0000_01fc;

    logic       clk;
    logic       rst_n;
    logic [3:0] ibus_max_delay;
    logic [3:0] dbus_max_delay;
    wb_req_t    ibus_req;
    wb_rsp_t    ibus_rsp;
    wb_req_t    dbus_req;
    wb_rsp_t    dbus_rsp;
    word_t      prog_q[$];
    word_t      exp_adr_q[$];
    word_t      exp_dat_q[$];
    int         error_count;
    int         check_count;
    int         test_count;
    int         cycle_count;

    tb_clock #(.PERIOD_NS(100)) clock_i (.clk_o(clk));

    mips_core #(.RESET_PC(RESET_PC_DEFAULT)) mips_core_i (
        .clk,
        .rst_n_i(rst_n),
        .ibus_req_o(ibus_req),
        .ibus_rsp_i(ibus_rsp),
        .dbus_req_o(dbus_req),
        .dbus_rsp_i(dbus_rsp)
    );

    wb_memory_model mem_i (
        .clk,
        .rst_n_i(rst_n),
        .ibus_max_delay_i(ibus_max_delay),
        .dbus_max_delay_i(dbus_max_delay),
        .ibus_req_i(ibus_req),
        .ibus_rsp_o(ibus_rsp),
        .dbus_req_i(dbus_req),
        .dbus_rsp_o(dbus_rsp)
    );

    function automatic word_t i_type(opcode_e op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic word_t r_type(funct_e fn, int rd, int rs, int rt);
        return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    task automatic compare(string name, word_t got, word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic begin_program();
        prog_q.delete();
        exp_adr_q.delete();
        exp_dat_q.delete();
    endtask

    task automatic emit(word_t w);
        prog_q.push_back(w);
    endtask

    // sw rt, adr(r0) and the value it must write
    task automatic store_reg(int rt, int adr, word_t value);
        emit(i_type(OP_SW, 0, rt, adr));
        exp_adr_q.push_back(32'(adr));
        exp_dat_q.push_back(value);
    endtask

    // marker store then spin on beq r0,r0,-1 with a nop in the slot
    task automatic end_program();
        store_reg(0, DONE_ADR, 32'h0);
        emit(i_type(OP_BEQ, 0, 0, -1));
        emit(32'h0);
    endtask

    task automatic run_program(string name, int imax, int dmax);
        int errors_before;
        int n;
        errors_before = error_count;
        @(posedge clk);
        #1;
        rst_n          = 1'b0;
        ibus_max_delay = 4'(imax);
        dbus_max_delay = 4'(dmax);
        for (int i = 0; i < 256; i++) begin
            mem_i.rom[i] = (i < prog_q.size()) ? prog_q[i] : '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        while (!(mem_i.store_count > 0 &&
                 mem_i.store_adr[mem_i.store_count - 1] == DONE_ADR)) begin
            @(negedge clk);
        end
        n = mem_i.store_count;
        compare("store_count", n, exp_adr_q.size());
        compare("ibus_bad_seen", 32'(mem_i.ibus_bad_seen), 32'h0);
        for (int k = 0; k < exp_adr_q.size() && k < n; k++) begin
            compare($sformatf("store[%0d].adr", k), mem_i.store_adr[k], exp_adr_q[k]);
            compare($sformatf("store[%0d].dat", k), mem_i.store_dat[k], exp_dat_q[k]);
            compare($sformatf("store[%0d].sel", k), 32'(mem_i.store_sel[k]), 32'hf);
        end
        test_count++;
        $display("test %s: %0d stores, %0d errors", name, n, error_count - errors_before);
    endtask

    task automatic test_alu(string name, int imax, int dmax);
        word_t a;
        word_t b;
        word_t c;
        a = (32'h1234 << 16) | 32'h5678;
        // -16 sign-extended
        b = 32'hffff_fff0;
        c = 32'h0000_0f0f;
        begin_program();
        emit(i_type(OP_LUI, 0, 1, 'h1234));
        emit(i_type(OP_ORI, 1, 1, 'h5678));
        emit(i_type(OP_ADDIU, 0, 2, -16));
        emit(i_type(OP_ADDIU, 0, 3, 'h0f0f));
        emit(i_type(OP_ORI, 0, 11, 'h8001));
        store_reg(1, 'h100, a);
        store_reg(2, 'h104, b);
        store_reg(11, 'h108, 32'h0000_8001);
        emit(r_type(FN_ADDU, 4, 1, 3));
        store_reg(4, 'h10c, a + c);
        emit(r_type(FN_SUBU, 5, 3, 1));
        store_reg(5, 'h110, c - a);
        emit(r_type(FN_AND, 6, 1, 2));
        store_reg(6, 'h114, a & b);
        emit(r_type(FN_OR, 7, 2, 3));
        store_reg(7, 'h118, b | c);
        emit(r_type(FN_XOR, 8, 1, 3));
        store_reg(8, 'h11c, a ^ c);
        emit(r_type(FN_SLT, 9, 2, 3));
        store_reg(9, 'h120, ($signed(b) < $signed(c)) ? 32'd1 : 32'd0);
        emit(r_type(FN_SLT, 10, 3, 2));
        store_reg(10, 'h124, ($signed(c) < $signed(b)) ? 32'd1 : 32'd0);
        end_program();
        run_program(name, imax, dmax);
    endtask

    task automatic test_forwarding(string name);
        begin_program();
        emit(i_type(OP_ADDIU, 0, 1, 5));
        emit(i_type(OP_ADDIU, 1, 1, 7));
        emit(i_type(OP_ADDIU, 1, 1, -3));
        emit(i_type(OP_ADDIU, 1, 1, 100));
        store_reg(1, 'h100, 32'(5 + 7 - 3 + 100));
        // producer two slots ahead comes from writeback
        emit(i_type(OP_ADDIU, 0, 4, 9));
        emit(32'h0);
        emit(r_type(FN_ADDU, 5, 4, 4));
        store_reg(5, 'h104, 32'(9 + 9));
        end_program();
        run_program(name, 0, 0);
    endtask

    task automatic test_branches(string name, int dmax);
        begin_program();
        emit(i_type(OP_ADDIU, 0, 3, 'h33));
        emit(i_type(OP_ADDIU, 0, 1, 1));
        emit(i_type(OP_ADDIU, 0, 2, 1));
        // taken branch skips one word past the slot
        emit(i_type(OP_BEQ, 1, 2, 2));
        store_reg(1, 'h100, 32'h1);
        emit(i_type(OP_SW, 0, 3, 'h104));
        store_reg(3, 'h108, 32'h33);
        // not taken, a taken one would skip the 0x110 store
        emit(i_type(OP_BNE, 1, 2, 2));
        store_reg(2, 'h10c, 32'h1);
        store_reg(3, 'h110, 32'h33);
        end_program();
        run_program(name, 0, dmax);
    endtask

    task automatic test_reg_zero(string name);
        begin_program();
        emit(i_type(OP_ADDIU, 0, 0, 'h55));
        store_reg(0, 'h100, 32'h0);
        emit(i_type(OP_ADDIU, 0, 1, 'h12));
        emit(r_type(FN_ADDU, 0, 1, 1));
        store_reg(0, 'h104, 32'h0);
        end_program();
        run_program(name, 0, 0);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst_n          = 1'b0;
        ibus_max_delay = 4'd0;
        dbus_max_delay = 4'd0;
        error_count    = 0;
        check_count    = 0;
        test_count     = 0;
        void'($urandom(32'h5b5f));
        test_alu("alu", 0, 0);
        test_forwarding("forwarding");
        test_branches("branches", 0);
        test_alu("alu_dbus_wait", 0, 5);
        test_branches("branches_dbus_wait", 5);
        test_alu("alu_ibus_wait", 5, 0);
        test_reg_zero("reg_zero");
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== verification/wb_memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_memory_model import mips_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n_i,
    input  wire logic [3:0] ibus_max_delay_i,
    input  wire logic [3:0] dbus_max_delay_i,
    input  wire wb_req_t    ibus_req_i,
    output wb_rsp_t         ibus_rsp_o,
    input  wire wb_req_t    dbus_req_i,
    output wb_rsp_t         dbus_rsp_o
);

    // program words by word address
    word_t      rom [256];
    word_t      store_adr [64];
    word_t      store_dat [64];
    logic [3:0] store_sel [64];
    int         store_count;
    // set by any fetch cycle that is not a full-word read
    logic       ibus_bad_seen;
    logic [3:0] i_wait_q;
    logic [3:0] i_delay_q;
    logic [3:0] d_wait_q;
    logic [3:0] d_delay_q;

    // random ack delay from 0 up to max_delay
    function automatic logic [3:0] pick_delay(logic [3:0] max_delay);
        return 4'($urandom % (32'(max_delay) + 32'd1));
    endfunction

    always_comb begin
        ibus_rsp_o.ack = ibus_req_i.cyc & ibus_req_i.stb & (i_wait_q >= i_delay_q);
        ibus_rsp_o.dat = rom[ibus_req_i.adr[9:2]];
        dbus_rsp_o.ack = dbus_req_i.cyc & dbus_req_i.stb & (d_wait_q >= d_delay_q);
        dbus_rsp_o.dat = '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            i_wait_q      <= '0;
            d_wait_q      <= '0;
            i_delay_q     <= pick_delay(ibus_max_delay_i);
            d_delay_q     <= pick_delay(dbus_max_delay_i);
            store_count   <= 0;
            ibus_bad_seen <= 1'b0;
        end else begin
            if (ibus_rsp_o.ack) begin
                i_wait_q  <= '0;
                i_delay_q <= pick_delay(ibus_max_delay_i);
            end else if (ibus_req_i.cyc && ibus_req_i.stb) begin
                i_wait_q <= i_wait_q + 4'd1;
            end
            if (ibus_req_i.cyc && (ibus_req_i.we || ibus_req_i.sel != 4'hf)) begin
                ibus_bad_seen <= 1'b1;
            end
            if (dbus_rsp_o.ack) begin
                d_wait_q  <= '0;
                d_delay_q <= pick_delay(dbus_max_delay_i);
            end else if (dbus_req_i.cyc && dbus_req_i.stb) begin
                d_wait_q <= d_wait_q + 4'd1;
            end
            // capture every acknowledged write in order
            if (dbus_rsp_o.ack && dbus_req_i.we) begin
                if (store_count < 64) begin
                    store_adr[store_count] <= dbus_req_i.adr;
                    store_dat[store_count] <= dbus_req_i.dat;
                    store_sel[store_count] <= dbus_req_i.sel;
                end
                store_count <= store_count + 1;
            end
        end
    end

endmodule

`default_nettype wire
